// File: tests/mpmc_lite_golden.txt
# name op sel adr dat expected, all but name and op in hex
# op W writes dat under sel, op R reads and compares with expected
full_w0 W ffff 00000000 00112233445566778899aabbccddeeff 0
full_r0 R ffff 00000000 0 00112233445566778899aabbccddeeff
full_w3 W ffff 00000030 0f1e2d3c4b5a69788796a5b4c3d2e1f0 0
full_w5 W ffff 00000050 55555555666666667777777788888888 0
full_r3 R 0000 00000030 0 0f1e2d3c4b5a69788796a5b4c3d2e1f0
part_w0 W 00ff 00000000 0123456789abcdeffedcba9876543210 0
part_r0 R 0000 00000000 0 0011223344556677fedcba9876543210
part_w3 W f00f 00000030 aaaaaaaabbbbbbbbccccccccdddddddd 0
part_r3 R 0000 00000030 0 aaaaaaaa4b5a69788796a5b4dddddddd
part_w5 W 8001 00000050 11111111111111111111111111111111 0
none_w5 W 0000 00000050 ffffffffffffffffffffffffffffffff 0
part_r5 R ffff 00000050 0 11555555666666667777777788888811
keep_r3a R 0000 00000030 0 aaaaaaaa4b5a69788796a5b4dddddddd
keep_r3b R ffff 00000030 0 aaaaaaaa4b5a69788796a5b4dddddddd
alias_r3 R 0000 ffffff3c 0 aaaaaaaa4b5a69788796a5b4dddddddd
bp_r0 R 0000 00000000 0 0011223344556677fedcba9876543210
bp_r3 R 0000 00000030 0 aaaaaaaa4b5a69788796a5b4dddddddd
bp_r5 R 0000 00000050 0 11555555666666667777777788888811
bp_r0b R 0000 00000000 0 0011223344556677fedcba9876543210
bp_r3b R 0000 00000030 0 aaaaaaaa4b5a69788796a5b4dddddddd

// File: mpmc_lite.f
source/mpmc_pkg.sv
source/req_if.sv
source/request_port.sv
source/request_fifo.sv
source/mem_sequencer.sv
source/mpmc_lite.sv
tests/mpmc_lite_asserts.sv
tests/mpmc_lite_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module mpmc_lite_tb -f mpmc_lite.f -o mpmc_lite_sim

# The log decides the result, not the simulator exit status
./obj_dir/mpmc_lite_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
	exit 0
fi
exit 1

// File: tests/mpmc_lite_tb.sv
`timescale 1ns/1ps

module mpmc_lite_tb import mpmc_pkg::*; ();

	// Cycle limits for the wait loops
	localparam int READ_TIMEOUT = 50;
	localparam int BUSY_TIMEOUT = 100;

	logic clk;
	logic reset;
	logic stb;
	logic we;
	byte_sel_t sel;
	logic [ADR_WIDTH-1:0] adr;
	mem_line_t dat_in;
	logic busy;
	logic rd_valid;
	mem_line_t rd_dat;
	req_tag_t rd_tag;

	// Reads in flight, oldest first, matching the order the sequencer serves them
	string exp_name_q[$];
	mem_line_t exp_line_q[$];
	req_tag_t exp_tag_q[$];

	// Tag the DUT should hand to the next accepted strobe
	req_tag_t next_tag;
	integer seed;
	int test_count;
	int check_count;
	int error_count;
	logic busy_seen;

	mpmc_lite dut0 (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	// ======================================================================
	// Compare tasks
	// ======================================================================

	task automatic check_line(input string name, input mem_line_t expected, input mem_line_t actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("FAILED %s: expected line %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_tag(input string name, input req_tag_t expected, input req_tag_t actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("FAILED %s: expected tag %0d, actual %0d", name, expected, actual);
		end
	endtask

	// ======================================================================
	// Bus driver and waits
	// ======================================================================

	// Called on a falling edge, the DUT samples the strobe on the next rising edge
	task automatic strobe(input logic is_write, input byte_sel_t s,
		input logic [ADR_WIDTH-1:0] a, input mem_line_t d);
		stb = 1'b1;
		we = is_write;
		sel = s;
		adr = a;
		dat_in = d;
		@(negedge clk);
		stb = 1'b0;
		next_tag++;
	endtask

	// Either waits for busy low or for the busy flag seen by the monitor below
	task automatic wait_busy(input logic want_seen, output logic ok);
		int cycles;
		cycles = 0;
		while ((want_seen ? !busy_seen : busy) && cycles < BUSY_TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		ok = want_seen ? busy_seen : !busy;
	endtask

	// The timeout restarts whenever one more read comes back
	task automatic drain_reads(output logic ok);
		int idle;
		int pending;
		idle = 0;
		pending = exp_name_q.size();
		while (exp_name_q.size() > 0 && idle < READ_TIMEOUT)
		begin
			@(negedge clk);
			idle = (exp_name_q.size() < pending) ? 0 : idle + 1;
			pending = exp_name_q.size();
		end
		ok = (exp_name_q.size() == 0);
		if (!ok)
		begin
			error_count++;
			$display("No read data arrived for %s within %0d cycles", exp_name_q[0], READ_TIMEOUT);
		end
	endtask

	// ======================================================================
	// Read return monitor
	// ======================================================================

	always @(negedge clk)
	begin
		int errs_before;
		if (busy)
			busy_seen = 1'b1;
		if (!reset && rd_valid)
		begin
			if (exp_name_q.size() == 0)
			begin
				error_count++;
				$display("Read data arrived with no read outstanding, tag %0d", rd_tag);
			end
			else
			begin
				errs_before = error_count;
				check_line(exp_name_q[0], exp_line_q[0], rd_dat);
				check_tag(exp_name_q[0], exp_tag_q[0], rd_tag);
				if (error_count == errs_before)
					$display("PASSED %s", exp_name_q[0]);
				void'(exp_name_q.pop_front());
				void'(exp_line_q.pop_front());
				void'(exp_tag_q.pop_front());
			end
		end
	end

	// ======================================================================
	// Golden file sequence
	// ======================================================================

	initial
	begin
		int fd;
		int n;
		int gap;
		logic ok;
		logic in_burst;
		string line;
		string name;
		string op;
		byte_sel_t f_sel;
		logic [ADR_WIDTH-1:0] f_adr;
		mem_line_t f_dat;
		mem_line_t f_exp;

		seed = 32'hb563d26b;
		reset = 1'b1;
		stb = 1'b0;
		we = 1'b0;
		sel = '0;
		adr = '0;
		dat_in = '0;
		next_tag = '0;
		test_count = 0;
		check_count = 0;
		error_count = 0;
		busy_seen = 1'b0;
		in_burst = 1'b0;
		ok = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		fd = $fopen("tests/mpmc_lite_golden.txt", "r");
		if (fd == 0)
		begin
			error_count++;
			ok = 1'b0;
			$display("Cannot open tests/mpmc_lite_golden.txt");
		end
		while (ok && !$feof(fd))
		begin
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%s %s %h %h %h %h", name, op, f_sel, f_adr, f_dat, f_exp);
			if (n != 6)
			begin
				error_count++;
				$display("Malformed golden line: %s", line);
				continue;
			end
			test_count++;
			// Lines named bp_ go out back to back to fill the FIFO
			if (name.substr(0, 2) != "bp_")
			begin
				gap = $random(seed) & 3;
				repeat (gap) @(negedge clk);
			end
			else if (!in_burst)
			begin
				in_burst = 1'b1;
				busy_seen = 1'b0;
			end
			wait_busy(1'b0, ok);
			if (!ok)
			begin
				error_count++;
				$display("Busy stayed high before %s", name);
				break;
			end
			if (op == "W")
			begin
				$display("DONE   %s write, tag %0d", name, next_tag);
				strobe(1'b1, f_sel, f_adr, f_dat);
			end
			else
			begin
				exp_name_q.push_back(name);
				exp_line_q.push_back(f_exp);
				exp_tag_q.push_back(next_tag);
				strobe(1'b0, f_sel, f_adr, f_dat);
				if (!in_burst)
					drain_reads(ok);
			end
		end
		if (fd != 0)
			$fclose(fd);

		// Collect the burst reads, then busy must have risen and must fall again
		if (ok)
			drain_reads(ok);
		if (ok && in_burst)
		begin
			wait_busy(1'b1, ok);
			if (ok)
				wait_busy(1'b0, ok);
			if (ok)
				$display("PASSED backpressure");
			else
			begin
				error_count++;
				$display("Busy did not rise and fall again around the request burst");
			end
		end
		repeat (2) @(negedge clk);

		// Protocol assertion failures count as errors too
		if (dut0.asserts0.fail_count != 0)
		begin
			error_count += dut0.asserts0.fail_count;
			$display("%0d protocol assertion failures during the run", dut0.asserts0.fail_count);
		end

		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: tests/mpmc_lite_asserts.sv
`timescale 1ns/1ps

// Protocol checks on the request path and the read return
module mpmc_lite_asserts (
	input logic clk,
	input logic reset,
	input logic busy,
	input logic rd_valid,
	input logic push,
	input logic full,
	input logic pop
);

	// Number of assertion failures so far
	int fail_count = 0;

	// ======================================================================
	// Read return and FIFO handshake
	// ======================================================================

	// Read data is presented for a single cycle
	rd_valid_pulse: assert property (@(posedge clk) disable iff (reset) rd_valid |=> !rd_valid)
		else
		begin
			fail_count++;
			$error("rd_valid high on two consecutive cycles");
		end

	// The port only pushes into a FIFO with room left
	push_not_full: assert property (@(posedge clk) disable iff (reset) push |-> !full)
		else
		begin
			fail_count++;
			$error("push while the request FIFO is full");
		end

	// The sequencer serves one request at a time, so a pop never repeats on the next cycle
	pop_single: assert property (@(posedge clk) disable iff (reset) pop |=> !pop)
		else
		begin
			fail_count++;
			$error("pop on two consecutive cycles");
		end

	// Reset clears the FIFO, so nothing holds the bus back afterwards
	busy_after_reset: assert property (@(posedge clk) reset |=> !busy)
		else
		begin
			fail_count++;
			$error("busy high in the cycle after reset");
		end

endmodule

bind mpmc_lite mpmc_lite_asserts asserts0 (
	.clk(clk),
	.reset(reset),
	.busy(busy),
	.rd_valid(rd_valid),
	.push(req0.push),
	.full(req0.full),
	.pop(req0.pop)
);

// File: source/mpmc_lite.sv
`timescale 1ns/1ps

module mpmc_lite import mpmc_pkg::*; (
	input logic clk,
	input logic reset,
	// Bus-side request strobe and payload
	input logic stb,
	input logic we,
	input byte_sel_t sel,
	input logic [ADR_WIDTH-1:0] adr,
	input mem_line_t dat_in,
	// Back-pressure towards the bus
	output logic busy,
	// Tagged read return
	output logic rd_valid,
	output mem_line_t rd_dat,
	output req_tag_t rd_tag
);

	// ======================================================================
	// Request path
	// ======================================================================

	// One request channel shared by the port, the FIFO and the sequencer
	req_if req0 ();

	// Takes strobes, tags them and pushes them a cycle later
	request_port port0 (
		.clk(clk),
		.reset(reset),
		.stb(stb),
		.we(we),
		.sel(sel),
		.adr(adr),
		.dat_in(dat_in),
		.busy(busy),
		.q(req0.producer)
	);

	// Four-entry buffer between the bus side and the sequencer
	request_fifo fifo0 (
		.clk(clk),
		.reset(reset),
		.q(req0.fifo)
	);

	// ======================================================================
	// Memory side
	// ======================================================================

	// Pops requests, applies the byte mask and returns tagged read data
	mem_sequencer seq0 (
		.clk(clk),
		.reset(reset),
		.q(req0.consumer),
		.rd_valid(rd_valid),
		.rd_dat(rd_dat),
		.rd_tag(rd_tag)
	);

endmodule

// File: source/mem_sequencer.sv
`timescale 1ns/1ps

module mem_sequencer import mpmc_pkg::*; (
	input logic clk,
	input logic reset,
	req_if.consumer q,
	output logic rd_valid,
	output mem_line_t rd_dat,
	output req_tag_t rd_tag
);

	mem_state_t state;

	// Internal line store, contents are undefined until written
	mem_line_t store [LINE_COUNT];

	// Request captured at pop time
	byte_sel_t mask;
	line_idx_t line_idx;
	logic cur_we;
	mem_line_t cur_dat;
	req_tag_t cur_tag;

	// Current line with the unmasked bytes replaced
	mem_line_t merged;

	// ======================================================================
	// Pop and state machine
	// ======================================================================

	// Pop whenever idle and something is waiting
	assign q.pop = (state == IDLE) && !q.empty;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			rd_valid <= 1'b0;
		end
		else
		begin
			case (state)
			IDLE:
			begin
				if (q.pop)
					state <= ACCESS;
			end
			ACCESS:
			begin
				// Writes finish here, reads go on to present their data
				if (cur_we)
					state <= IDLE;
				else
				begin
					state <= RESPOND;
					rd_valid <= 1'b1;
				end
			end
			RESPOND:
			begin
				// Read data is valid for this single cycle
				rd_valid <= 1'b0;
				state <= IDLE;
			end
			default:
				state <= IDLE;
			endcase
		end
	end

	// ======================================================================
	// Request capture and write mask
	// ======================================================================

	// The mask is only built in IDLE, on the cycle the head is popped
	// A mask bit of 1 keeps the stored byte
	always_ff @(posedge clk)
	begin
		if (state == IDLE && q.pop)
		begin
			if (q.head.we)
				mask <= ~q.head.sel;
			else
				mask <= '0;	// a read takes every byte
			cur_we <= q.head.we;
			cur_dat <= q.head.dat;
			cur_tag <= q.head.tag;
			line_idx <= q.head.adr[LINE_ADR_LSB +: LINE_ADR_BITS];
		end
	end

	// ======================================================================
	// Line store access
	// ======================================================================

	// Byte merge of the new data into the addressed line
	always_comb
	begin
		merged = store[line_idx];
		for (int i = 0; i < SEL_WIDTH; i++)
		begin
			if (!mask[i])
				merged[i*BYTE_BITS +: BYTE_BITS] = cur_dat[i*BYTE_BITS +: BYTE_BITS];
		end
	end

	// A write stores the merged line, a read latches the line and its tag
	always_ff @(posedge clk)
	begin
		if (state == ACCESS)
		begin
			if (cur_we)
				store[line_idx] <= merged;
			else
			begin
				rd_dat <= store[line_idx];
				rd_tag <= cur_tag;
			end
		end
	end

endmodule

// File: source/request_fifo.sv
`timescale 1ns/1ps

module request_fifo import mpmc_pkg::*; (
	input logic clk,
	input logic reset,
	req_if.fifo q
);

	// Circular request storage
	mem_req_t entries [FIFO_DEPTH];

	logic [FIFO_PTR_BITS-1:0] wr_ptr;
	logic [FIFO_PTR_BITS-1:0] rd_ptr;
	// Occupancy, one bit wider than the pointers so that 4 fits
	logic [FIFO_CNT_BITS-1:0] count;

	logic do_push;
	logic do_pop;

	// ======================================================================
	// Levels and head
	// ======================================================================

	assign q.full = (count == FIFO_CNT_BITS'(FIFO_DEPTH));
	assign q.almost_full = (count == FIFO_CNT_BITS'(FIFO_DEPTH - 1));
	assign q.empty = (count == '0);

	// The oldest entry is always presented on head
	assign q.head = entries[rd_ptr];

	// A push into a full buffer or a pop from an empty one is ignored
	assign do_push = q.push && !q.full;
	assign do_pop = q.pop && !q.empty;

	// ======================================================================
	// Storage
	// ======================================================================

	always_ff @(posedge clk)
	begin
		if (do_push)
			entries[wr_ptr] <= q.push_req;
	end

	// ======================================================================
	// Pointers and occupancy
	// ======================================================================

	// Depth is a power of two so the pointers wrap on their own
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Push and pop on the same cycle leave the count unchanged
	always_ff @(posedge clk)
	begin
		if (reset)
			count <= '0;
		else
		begin
			case ({do_push, do_pop})
			2'b10:
				count <= count + 1'b1;
			2'b01:
				count <= count - 1'b1;
			default:
				count <= count;
			endcase
		end
	end

endmodule

// File: source/request_port.sv
`timescale 1ns/1ps

module request_port import mpmc_pkg::*; (
	input logic clk,
	input logic reset,
	input logic stb,
	input logic we,
	input byte_sel_t sel,
	input logic [ADR_WIDTH-1:0] adr,
	input mem_line_t dat_in,
	output logic busy,
	req_if.producer q
);

	// Tag handed to the next accepted request, wraps at 16
	req_tag_t tag_cnt;
	logic accept;
	mem_req_t req_d;

	// ======================================================================
	// Acceptance
	// ======================================================================

	// Busy follows the FIFO full level
	// A push still in flight into the last free slot also counts as full,
	// since the strobe taken now lands one cycle later
	assign busy = q.full || (q.push && q.almost_full);

	// A strobe seen while busy is low is taken, otherwise it is dropped
	assign accept = stb && !busy;

	// Assemble the request from the bus inputs and the current tag
	always_comb
	begin
		req_d.we = we;
		req_d.sel = sel;
		req_d.adr = adr;
		req_d.dat = dat_in;
		req_d.tag = tag_cnt;
	end

	// ======================================================================
	// Push and tag registers
	// ======================================================================

	// The push pulse follows the strobe by one cycle
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			q.push <= 1'b0;
			tag_cnt <= '0;
		end
		else
		begin
			q.push <= accept;
			// Dropped strobes do not consume a tag
			if (accept)
				tag_cnt <= tag_cnt + 1'b1;
		end
	end

	// Request payload, only loaded on an accepted strobe
	always_ff @(posedge clk)
	begin
		if (accept)
			q.push_req <= req_d;
	end

endmodule

// File: source/req_if.sv
`timescale 1ns/1ps

// Request path between the bus-side port, the FIFO and the sequencer
interface req_if import mpmc_pkg::*; ();

	// Push side, driven by the request port
	logic push;
	mem_req_t push_req;

	// Buffer levels, driven by the FIFO
	logic full;
	// High when only one free slot is left
	logic almost_full;
	logic empty;

	// Pop side
	logic pop;
	mem_req_t head;

	// The request port pushes tagged requests and watches the levels
	modport producer (
		output push,
		output push_req,
		input full,
		input almost_full
	);

	// The sequencer pops the head entry
	modport consumer (
		output pop,
		input head,
		input empty
	);

	// The FIFO itself sees both sides of the buffer
	modport fifo (
		input push,
		input push_req,
		input pop,
		output full,
		output almost_full,
		output head,
		output empty
	);

endinterface

// File: source/mpmc_pkg.sv
package mpmc_pkg;

	// ======================================================================
	// Bus and line geometry
	// ======================================================================

	// One line is 128 bits wide and carries 16 byte selects
	localparam int DATA_WIDTH = 128;
	localparam int SEL_WIDTH = 16;
	localparam int BYTE_BITS = DATA_WIDTH / SEL_WIDTH;
	localparam int ADR_WIDTH = 32;

	// The line index comes from address bits 7 to 4
	localparam int LINE_ADR_LSB = 4;
	localparam int LINE_ADR_BITS = 4;
	localparam int LINE_COUNT = 1 << LINE_ADR_BITS;

	// Request buffer and tag sizes
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_BITS = 2;
	localparam int FIFO_CNT_BITS = 3;
	localparam int TAG_WIDTH = 4;

	// ======================================================================
	// Shared types
	// ======================================================================

	typedef logic [DATA_WIDTH-1:0] mem_line_t;
	typedef logic [SEL_WIDTH-1:0] byte_sel_t;
	typedef logic [TAG_WIDTH-1:0] req_tag_t;
	typedef logic [LINE_ADR_BITS-1:0] line_idx_t;

	// One tagged bus request as it sits in the request FIFO
	typedef struct packed {
		logic we;
		byte_sel_t sel;
		logic [ADR_WIDTH-1:0] adr;
		mem_line_t dat;
		req_tag_t tag;
	} mem_req_t;

	// Sequencer states
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		ACCESS = 2'd1,
		RESPOND = 2'd2
	} mem_state_t;

endpackage
